/* common/tlb_miss_pkg.sv */
`default_nettype none

package tlb_miss_pkg;

  // pipeline shape
  localparam int LANES = 2;
  localparam int ROWS = 4;

  // page is vaddr[43:14]
  localparam int VADDR_W = 44;
  localparam int PAGE_LSB = 14;
  localparam int PAGE_W = VADDR_W - PAGE_LSB;

  typedef logic [1:0] row_ptr_t;
  typedef logic [2:0] row_cnt_t;
  typedef logic [VADDR_W-1:0] vaddr_t;
  typedef logic [PAGE_W-1:0] page_t;

  typedef enum logic [1:0] {
    OP_LOAD,
    OP_STORE,
    OP_PREFETCH,
    OP_NONE
  } op_kind_e;

  // one memory op as seen on a lane
  typedef struct packed {
    logic       thread;
    vaddr_t     vaddr;
    logic [4:0] sz;
    logic [3:0] attr;
    logic [8:0] lsq_tag;
    logic [9:0] ii_tag;
    op_kind_e   kind;
  } mem_op_t;

  typedef mem_op_t [LANES-1:0] lane_ops_t;

  // execute-address request per lane
  typedef struct packed {
    logic       en;
    vaddr_t     vaddr;
    logic [4:0] sz;
    logic [3:0] attr;
  } ex_req_t;

  // request to the TLB refill unit
  typedef struct packed {
    logic       en;
    page_t      page;
    logic [3:0] attr;
  } refill_req_t;

  typedef enum logic [1:0] {
    RS_IDLE,
    RS_READ,
    RS_REFILL,
    RS_ISSUE
  } replay_state_e;

endpackage

`default_nettype wire

/* replay_buffer/replay_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module replay_ctrl import tlb_miss_pkg::*; (
  input  wire              clk,
  input  wire              rst,
  input  wire [LANES-1:0]  miss_i,
  input  wire              refill_ack_i,
  input  wire [LANES-1:0]  lane_live_i,
  input  wire lane_ops_t   rd_ops_i,
  output row_ptr_t         wr_row_o,
  output row_ptr_t         rd_row_o,
  output logic             rd_strobe_o,
  output logic             issue_o,
  output refill_req_t      refill_req_o,
  output logic             stall_o
);

  replay_state_e    state_q;
  replay_state_e    state_d;
  row_ptr_t         wr_ptr_q;
  row_ptr_t         rd_ptr_q;
  row_cnt_t         cnt_q;
  row_cnt_t         cnt_d;
  logic [LANES-1:0] done_q;
  logic [LANES-1:0] need;
  logic             capture;
  logic             issue;
  logic             req_en;
  logic             cur_lane;
  logic             lane_q;
  logic             req_out_q;
  logic             ack_q;

  assign capture = |miss_i;
  assign issue = (state_q == RS_ISSUE);

  // live lanes of the read row still waiting for their page
  assign need = lane_live_i & ~done_q;

  // lane 0 goes first unless a request is already out on a lane
  assign cur_lane = req_out_q ? lane_q : ~need[0];

  // request gap of one cycle after every ack
  assign req_en = (state_q == RS_REFILL) && !ack_q && need[cur_lane];

  assign cnt_d = cnt_q + row_cnt_t'(capture) - row_cnt_t'(issue);

  always_comb begin
    state_d = state_q;
    case (state_q)
      RS_IDLE: begin
        if (cnt_q != '0) begin
          state_d = RS_READ;
        end
      end
      RS_READ: begin
        state_d = RS_REFILL;
      end
      RS_REFILL: begin
        // a killed lane with a request in flight still waits for its ack
        if (!(|need) && !req_out_q) begin
          state_d = RS_ISSUE;
        end
      end
      RS_ISSUE: begin
        state_d = (cnt_d != '0) ? RS_READ : RS_IDLE;
      end
      default: begin
        state_d = RS_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= RS_IDLE;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q <= '0;
      done_q <= '0;
      lane_q <= 1'b0;
      req_out_q <= 1'b0;
      ack_q <= 1'b0;
    end else begin
      state_q <= state_d;
      cnt_q <= cnt_d;
      ack_q <= refill_ack_i;
      if (capture) begin
        wr_ptr_q <= wr_ptr_q + row_ptr_t'(1);
      end
      if (issue) begin
        rd_ptr_q <= rd_ptr_q + row_ptr_t'(1);
        done_q <= '0;
      end else if (refill_ack_i && req_out_q) begin
        done_q[lane_q] <= 1'b1;
      end
      if (refill_ack_i) begin
        req_out_q <= 1'b0;
      end else if (req_en && !req_out_q) begin
        req_out_q <= 1'b1;
        lane_q <= cur_lane;
      end
    end
  end

  assign wr_row_o = wr_ptr_q;
  assign rd_row_o = rd_ptr_q;
  assign rd_strobe_o = (state_q == RS_READ);
  assign issue_o = issue;

  // page and attr of the requesting lane
  assign refill_req_o.en = req_en;
  assign refill_req_o.page = rd_ops_i[cur_lane].vaddr[PAGE_LSB +: PAGE_W];
  assign refill_req_o.attr = rd_ops_i[cur_lane].attr;

  // high while any row is held up to and including its issue cycle
  assign stall_o = (cnt_q != '0);

  a_no_capture_full: assert property (
    @(posedge clk) disable iff (rst) capture |-> (cnt_q < row_cnt_t'(ROWS))
  ) else $error("miss captured with all rows occupied");

  a_ack_has_req: assert property (
    @(posedge clk) disable iff (rst) refill_ack_i |-> req_out_q
  ) else $error("refill ack without an outstanding request");

  a_idle_when_empty: assert property (
    @(posedge clk) disable iff (rst) (cnt_q == '0) |-> (state_q == RS_IDLE)
  ) else $error("replay active with no rows held");

endmodule

`default_nettype wire

/* replay_buffer/miss_entry_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module miss_entry_ram import tlb_miss_pkg::*; (
  input  wire             clk,
  input  wire             rst,
  input  wire             wr_en_i,
  input  wire row_ptr_t   wr_row_i,
  input  wire lane_ops_t  wr_ops_i,
  input  wire             rd_strobe_i,
  input  wire row_ptr_t   rd_row_i,
  output lane_ops_t       rd_ops_o
);

  // both lanes of one capture share a row
  lane_ops_t mem [ROWS];
  row_ptr_t  rd_addr_q;

  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem[wr_row_i] <= wr_ops_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_addr_q <= '0;
    end else if (rd_strobe_i) begin
      rd_addr_q <= rd_row_i;
    end
  end

  // async read after the address register, so a write to
  // the held row shows up on the next cycle (write first)
  assign rd_ops_o = mem[rd_addr_q];

endmodule

`default_nettype wire

/* logic/miss_tag_table.sv */
`timescale 1ns/1ps
`default_nettype none

module miss_tag_table import tlb_miss_pkg::*; (
  input  wire              clk,
  input  wire              rst,
  input  wire [LANES-1:0]  miss_i,
  input  wire [LANES-1:0]  thread_i,
  input  wire row_ptr_t    wr_row_i,
  input  wire row_ptr_t    rd_row_i,
  input  wire              issue_i,
  input  wire              except_i,
  input  wire              except_thread_i,
  output logic [LANES-1:0] lane_live_o
);

  logic [LANES-1:0] pend_q [ROWS];
  logic [LANES-1:0] inv_q [ROWS];
  logic [LANES-1:0] thr_q [ROWS];
  logic             capture;
  logic [LANES-1:0] kill_wr;
  logic [LANES-1:0] kill_rd;

  // lanes hit by the exception in this cycle
  function automatic logic [LANES-1:0] thread_hit(input logic [LANES-1:0] thr,
                                                  input logic             ex,
                                                  input logic             ex_thr);
    return {LANES{ex}} & ~(thr ^ {LANES{ex_thr}});
  endfunction

  assign capture = |miss_i;
  assign kill_wr = thread_hit(thread_i, except_i, except_thread_i);
  assign kill_rd = thread_hit(thr_q[rd_row_i], except_i, except_thread_i);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int r = 0; r < ROWS; r++) begin
        pend_q[r] <= '0;
        inv_q[r] <= '0;
      end
    end else begin
      if (except_i) begin
        for (int r = 0; r < ROWS; r++) begin
          inv_q[r] <= inv_q[r] |
                      (pend_q[r] & thread_hit(thr_q[r], except_i, except_thread_i));
        end
      end
      if (issue_i) begin
        pend_q[rd_row_i] <= '0;
      end
      // a row captured under the exception starts out invalid
      if (capture) begin
        pend_q[wr_row_i] <= miss_i;
        inv_q[wr_row_i] <= kill_wr;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      thr_q[wr_row_i] <= thread_i;
    end
  end

  assign lane_live_o = pend_q[rd_row_i] & ~inv_q[rd_row_i] & ~kill_rd;

  // write pointer must never lap a row that has not issued yet
  a_no_overwrite: assert property (
    @(posedge clk) disable iff (rst) capture |-> (pend_q[wr_row_i] == '0)
  ) else $error("pending row rewritten before issue");

endmodule

`default_nettype wire

/* logic/op_return_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module op_return_mux import tlb_miss_pkg::*; (
  input  wire              issue_i,
  input  wire lane_ops_t   rd_ops_i,
  input  wire [LANES-1:0]  lane_live_i,
  input  wire lane_ops_t   lane_op_i,
  input  wire [LANES-1:0]  lane_en_i,
  output lane_ops_t        lane_op_o,
  output logic [LANES-1:0] lane_en_o,
  output ex_req_t [LANES-1:0] ex_req_o
);

  always_comb begin
    // replayed row wins for its one issue cycle
    if (issue_i) begin
      lane_op_o = rd_ops_i;
      lane_en_o = lane_live_i;
    end else begin
      lane_op_o = lane_op_i;
      lane_en_o = lane_en_i;
    end
  end

  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      // dead lanes keep their payload but never request
      ex_req_o[l].en = issue_i & lane_live_i[l];
      ex_req_o[l].vaddr = lane_op_o[l].vaddr;
      ex_req_o[l].sz = lane_op_o[l].sz;
      ex_req_o[l].attr = lane_op_o[l].attr;
    end
  end

endmodule

`default_nettype wire

/* logic/tlb_miss_replay.sv */
`timescale 1ns/1ps
`default_nettype none

module tlb_miss_replay import tlb_miss_pkg::*; (
  input  wire              clk,
  input  wire              rst,
  input  wire lane_ops_t   lane_op_i,
  input  wire [LANES-1:0]  lane_en_i,
  input  wire [LANES-1:0]  miss_i,
  input  wire              except_i,
  input  wire              except_thread_i,
  input  wire              refill_ack_i,
  output lane_ops_t        lane_op_o,
  output logic [LANES-1:0] lane_en_o,
  output ex_req_t [LANES-1:0] ex_req_o,
  output refill_req_t      refill_req_o,
  output logic             stall_o
);

  row_ptr_t         wr_row;
  row_ptr_t         rd_row;
  logic             rd_strobe;
  logic             issue;
  logic [LANES-1:0] lane_live;
  logic [LANES-1:0] lane_thread;
  lane_ops_t        rd_ops;

  // thread bit of each incoming lane for the tag table
  for (genvar l = 0; l < LANES; l++) begin : g_thread
    assign lane_thread[l] = lane_op_i[l].thread;
  end

  replay_ctrl u_replay_ctrl (
    .clk          (clk),
    .rst          (rst),
    .miss_i       (miss_i),
    .refill_ack_i (refill_ack_i),
    .lane_live_i  (lane_live),
    .rd_ops_i     (rd_ops),
    .wr_row_o     (wr_row),
    .rd_row_o     (rd_row),
    .rd_strobe_o  (rd_strobe),
    .issue_o      (issue),
    .refill_req_o (refill_req_o),
    .stall_o      (stall_o)
  );

  miss_entry_ram u_miss_entry_ram (
    .clk         (clk),
    .rst         (rst),
    .wr_en_i     (|miss_i),
    .wr_row_i    (wr_row),
    .wr_ops_i    (lane_op_i),
    .rd_strobe_i (rd_strobe),
    .rd_row_i    (rd_row),
    .rd_ops_o    (rd_ops)
  );

  miss_tag_table u_miss_tag_table (
    .clk             (clk),
    .rst             (rst),
    .miss_i          (miss_i),
    .thread_i        (lane_thread),
    .wr_row_i        (wr_row),
    .rd_row_i        (rd_row),
    .issue_i         (issue),
    .except_i        (except_i),
    .except_thread_i (except_thread_i),
    .lane_live_o     (lane_live)
  );

  op_return_mux u_op_return_mux (
    .issue_i     (issue),
    .rd_ops_i    (rd_ops),
    .lane_live_i (lane_live),
    .lane_op_i   (lane_op_i),
    .lane_en_i   (lane_en_i),
    .lane_op_o   (lane_op_o),
    .lane_en_o   (lane_en_o),
    .ex_req_o    (ex_req_o)
  );

endmodule

`default_nettype wire

/* sim/tb_tlb_miss_replay.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_tlb_miss_replay import tlb_miss_pkg::*; ();

  // six tests of up to four rows at about 20 cycles each plus margin
  localparam int MAX_CYCLES = 3000;

  logic                clk;
  logic                rst;
  lane_ops_t           lane_op_i;
  logic [LANES-1:0]    lane_en_i;
  logic [LANES-1:0]    miss_i;
  logic                except_i;
  logic                except_thread_i;
  logic                refill_ack_i;
  lane_ops_t           lane_op_o;
  logic [LANES-1:0]    lane_en_o;
  ex_req_t [LANES-1:0] ex_req_o;
  refill_req_t         refill_req_o;
  logic                stall_o;

  logic [31:0]         rng_state = 32'd21;
  int                  cycles = 0;

  // observed issue cycles and refill requests
  lane_ops_t           seen_ops [$];
  logic [LANES-1:0]    seen_en [$];
  ex_req_t [LANES-1:0] seen_ex [$];
  refill_req_t         seen_refills [$];

  // expected rows in capture order
  lane_ops_t           exp_ops [$];
  logic [LANES-1:0]    exp_live [$];
  refill_req_t         exp_refills [$];

  tlb_miss_replay u_tlb_miss_replay (
    .clk             (clk),
    .rst             (rst),
    .lane_op_i       (lane_op_i),
    .lane_en_i       (lane_en_i),
    .miss_i          (miss_i),
    .except_i        (except_i),
    .except_thread_i (except_thread_i),
    .refill_ack_i    (refill_ack_i),
    .lane_op_o       (lane_op_o),
    .lane_en_o       (lane_en_o),
    .ex_req_o        (ex_req_o),
    .refill_req_o    (refill_req_o),
    .stall_o         (stall_o)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic mem_op_t make_op(input logic thread, input op_kind_e kind);
    mem_op_t     op;
    logic [31:0] hi;
    logic [31:0] lo;
    hi = next_rand();
    lo = next_rand();
    op.thread = thread;
    op.vaddr = {hi[11:0], lo};
    op.sz = hi[16:12];
    op.attr = hi[20:17];
    op.lsq_tag = lo[8:0] ^ hi[29:21];
    op.ii_tag = {hi[31:30], lo[31:24]};
    op.kind = kind;
    return op;
  endfunction

  // bubble on both lanes that never matches a stored op
  function automatic lane_ops_t idle_ops();
    lane_ops_t ops;
    ops = '0;
    for (int l = 0; l < LANES; l++) begin
      ops[l].kind = OP_NONE;
    end
    return ops;
  endfunction

  function automatic ex_req_t ex_of(input mem_op_t op, input logic en);
    ex_req_t r;
    r.en = en;
    r.vaddr = op.vaddr;
    r.sz = op.sz;
    r.attr = op.attr;
    return r;
  endfunction

  // page is the address above the 16 KB offset
  function automatic refill_req_t refill_of(input mem_op_t op);
    refill_req_t r;
    r.en = 1'b1;
    r.page = op.vaddr[PAGE_LSB +: PAGE_W];
    r.attr = op.attr;
    return r;
  endfunction

  // issue cycle shows stall still high and a stored op on the lanes
  function automatic logic replaying();
    return stall_o && (lane_op_o != lane_op_i);
  endfunction

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_op(input string name, input mem_op_t exp, input mem_op_t act);
    if (act !== exp) begin
      fail_now($sformatf("** Error %s: expected %h, got %h", name, exp, act));
    end
  endtask

  task automatic check_ex(input string name, input ex_req_t exp, input ex_req_t act);
    if (act !== exp) begin
      fail_now($sformatf("** Error %s: expected %h, got %h", name, exp, act));
    end
  endtask

  task automatic check_refill(input string name, input refill_req_t exp,
                              input refill_req_t act);
    if (act !== exp) begin
      fail_now($sformatf("** Error %s: expected %h, got %h", name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      fail_now($sformatf("** Error %s: expected %h, got %h", name, exp, act));
    end
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      fail_now($sformatf("run did not finish within %0d cycles", MAX_CYCLES));
    end
  end

  // refill unit model with a random ack delay of 1 to 4 cycles
  always begin : refill_responder
    int unsigned delay;
    @(posedge clk);
    if (!rst && refill_req_o.en) begin
      seen_refills.push_back(refill_req_o);
      delay = 1 + next_rand() % 4;
      repeat (delay) @(negedge clk);
      refill_ack_i = 1'b1;
      @(negedge clk);
      refill_ack_i = 1'b0;
    end
  end

  always @(posedge clk) begin
    if (!rst && replaying()) begin
      seen_ops.push_back(lane_op_o);
      seen_en.push_back(lane_en_o);
      seen_ex.push_back(ex_req_o);
    end
  end

  task automatic expect_row(input lane_ops_t ops, input logic [LANES-1:0] live);
    exp_ops.push_back(ops);
    exp_live.push_back(live);
    for (int l = 0; l < LANES; l++) begin
      if (live[l]) begin
        exp_refills.push_back(refill_of(ops[l]));
      end
    end
  endtask

  task automatic capture_row(input lane_ops_t ops, input logic [LANES-1:0] miss);
    @(negedge clk);
    lane_op_i = ops;
    lane_en_i = miss;
    miss_i = miss;
    except_i = 1'b0;
  endtask

  task automatic go_idle();
    @(negedge clk);
    lane_op_i = idle_ops();
    lane_en_i = '0;
    miss_i = '0;
    except_i = 1'b0;
    except_thread_i = 1'b0;
  endtask

  // stall must drop right after the last issue cycle
  task automatic wait_drain();
    logic was_issue;
    was_issue = 1'b0;
    @(posedge clk);
    check_bit("stall_o", 1'b1, stall_o);
    while (stall_o) begin
      was_issue = replaying();
      @(posedge clk);
    end
    if (!was_issue) begin
      fail_now("stall_o dropped without an issue cycle just before it");
    end
  endtask

  task automatic compare_results(input string test);
    lane_ops_t           ops;
    lane_ops_t           got;
    logic [LANES-1:0]    live;
    logic [LANES-1:0]    en;
    ex_req_t [LANES-1:0] ex;
    int                  row;
    if (seen_ops.size() != exp_ops.size()) begin
      fail_now($sformatf("%s: saw %0d issue cycles instead of %0d", test,
                         seen_ops.size(), exp_ops.size()));
    end
    if (seen_refills.size() != exp_refills.size()) begin
      fail_now($sformatf("%s: saw %0d refill requests instead of %0d", test,
                         seen_refills.size(), exp_refills.size()));
    end
    row = 0;
    while (exp_ops.size() > 0) begin
      ops = exp_ops.pop_front();
      live = exp_live.pop_front();
      got = seen_ops.pop_front();
      en = seen_en.pop_front();
      ex = seen_ex.pop_front();
      for (int l = 0; l < LANES; l++) begin
        check_op($sformatf("lane_op_o[%0d] (%s, row %0d)", l, test, row), ops[l], got[l]);
        check_bit($sformatf("lane_en_o[%0d] (%s, row %0d)", l, test, row), live[l], en[l]);
        check_ex($sformatf("ex_req_o[%0d] (%s, row %0d)", l, test, row),
                 ex_of(ops[l], live[l]), ex[l]);
      end
      row++;
    end
    while (exp_refills.size() > 0) begin
      check_refill($sformatf("refill_req_o (%s)", test), exp_refills.pop_front(),
                   seen_refills.pop_front());
    end
  endtask

  task automatic test_reset_pass_through();
    lane_ops_t ops;
    @(posedge clk);
    check_bit("stall_o", 1'b0, stall_o);
    check_bit("refill_req_o.en", 1'b0, refill_req_o.en);
    for (int i = 0; i < 4; i++) begin
      ops[0] = make_op(i[0], OP_LOAD);
      ops[1] = make_op(i[1], OP_STORE);
      @(negedge clk);
      lane_op_i = ops;
      lane_en_i = i[LANES-1:0];
      @(posedge clk);
      check_bit("stall_o", 1'b0, stall_o);
      check_bit("refill_req_o.en", 1'b0, refill_req_o.en);
      for (int l = 0; l < LANES; l++) begin
        check_op($sformatf("lane_op_o[%0d]", l), ops[l], lane_op_o[l]);
        check_bit($sformatf("lane_en_o[%0d]", l), lane_en_i[l], lane_en_o[l]);
        check_bit($sformatf("ex_req_o[%0d].en", l), 1'b0, ex_req_o[l].en);
      end
    end
    go_idle();
  endtask

  task automatic test_single_lane();
    lane_ops_t ops;
    ops[0] = make_op(1'b0, OP_LOAD);
    ops[1] = make_op(1'b1, OP_STORE);
    expect_row(ops, 2'b01);
    capture_row(ops, 2'b01);
    go_idle();
    wait_drain();
    compare_results("single lane");
  endtask

  task automatic test_both_lanes();
    lane_ops_t ops;
    ops[0] = make_op(1'b1, OP_STORE);
    ops[1] = make_op(1'b0, OP_LOAD);
    expect_row(ops, 2'b11);
    capture_row(ops, 2'b11);
    go_idle();
    wait_drain();
    compare_results("both lanes");
  endtask

  task automatic test_four_rows();
    lane_ops_t        rows [4];
    logic [LANES-1:0] miss [4];
    miss = '{2'b01, 2'b11, 2'b10, 2'b11};
    for (int r = 0; r < 4; r++) begin
      rows[r][0] = make_op(r[0], OP_LOAD);
      rows[r][1] = make_op(r[1], OP_PREFETCH);
      expect_row(rows[r], miss[r]);
    end
    for (int r = 0; r < 4; r++) begin
      capture_row(rows[r], miss[r]);
    end
    go_idle();
    wait_drain();
    compare_results("four rows");
  endtask

  task automatic test_exception();
    lane_ops_t a;
    lane_ops_t b;
    a[0] = make_op(1'b0, OP_LOAD);
    a[1] = make_op(1'b1, OP_STORE);
    b[0] = make_op(1'b1, OP_LOAD);
    b[1] = make_op(1'b1, OP_LOAD);
    expect_row(a, 2'b01);
    expect_row(b, 2'b00);
    capture_row(a, 2'b11);
    capture_row(b, 2'b11);
    // thread 1 flushed while b is being captured
    except_i = 1'b1;
    except_thread_i = 1'b1;
    go_idle();
    wait_drain();
    compare_results("exception");
  endtask

  task automatic test_capture_in_refill();
    lane_ops_t a;
    lane_ops_t b;
    a[0] = make_op(1'b0, OP_STORE);
    a[1] = make_op(1'b0, OP_LOAD);
    b[0] = make_op(1'b1, OP_PREFETCH);
    b[1] = make_op(1'b1, OP_LOAD);
    expect_row(a, 2'b11);
    expect_row(b, 2'b01);
    capture_row(a, 2'b11);
    go_idle();
    @(posedge clk);
    while (!refill_req_o.en) begin
      @(posedge clk);
    end
    capture_row(b, 2'b01);
    go_idle();
    wait_drain();
    compare_results("capture during replay");
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    lane_op_i = idle_ops();
    lane_en_i = '0;
    miss_i = '0;
    except_i = 1'b0;
    except_thread_i = 1'b0;
    refill_ack_i = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    test_reset_pass_through();
    test_single_lane();
    test_both_lanes();
    test_four_rows();
    test_exception();
    test_capture_in_refill();

    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

/* tlb_miss_replay.f */
common/tlb_miss_pkg.sv
replay_buffer/replay_ctrl.sv
replay_buffer/miss_entry_ram.sv
logic/miss_tag_table.sv
logic/op_return_mux.sv
logic/tlb_miss_replay.sv
sim/tb_tlb_miss_replay.sv
